/* verilog/video_pkg.sv */
package video_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	localparam int TIMING_W   = 12;
	localparam int IO_W       = 16;
	localparam int LED_W      = 8;
	localparam int NUM_SYNC   = 2;
	localparam int SYNC_CNT_W = 16;

	// Every timing port and register
	typedef logic [TIMING_W-1:0] timing_t;

	//////////////////////////////
	// Reset timing, 1920x1080 at 60 Hz
	//////////////////////////////

	localparam timing_t DEF_WIDTH  = 12'd1920;
	localparam timing_t DEF_HFP    = 12'd88;
	localparam timing_t DEF_HS     = 12'd48;
	localparam timing_t DEF_HBP    = 12'd148;
	localparam timing_t DEF_HEIGHT = 12'd1080;
	localparam timing_t DEF_VFP    = 12'd4;
	localparam timing_t DEF_VS     = 12'd5;
	localparam timing_t DEF_VBP    = 12'd36;

	// Data words carried by a timing command
	localparam int NUM_TIMING_WORDS = 8;

	//////////////////////////////
	// Host commands
	//////////////////////////////

	typedef enum logic [7:0] {
		CMD_NONE    = 8'h00,
		CMD_TIMING  = 8'h20,
		CMD_LED     = 8'h25,
		CMD_VSET    = 8'h27,
		CMD_VS_WAIT = 8'h30,
		CMD_HSET    = 8'h37
	} cmd_e;

	typedef enum logic {
		ST_IDLE,
		ST_DATA
	} dec_state_e;

endpackage

/* verilog/hps_cmd_decoder.sv */
module hps_cmd_decoder
	import video_pkg::*;
(
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_io_sel,
	input  logic             i_io_clk,
	input  logic [IO_W-1:0]  i_io_din,
	input  logic             i_vs_fixed,
	output logic             o_io_ack,
	output logic [LED_W-1:0] o_led,
	output timing_t          o_width,
	output timing_t          o_hfp,
	output timing_t          o_hs_len,
	output timing_t          o_hbp,
	output timing_t          o_height,
	output timing_t          o_vfp,
	output timing_t          o_vs_len,
	output timing_t          o_vbp,
	output timing_t          o_vset,
	output timing_t          o_hset
);

	logic                              rack;
	logic                              io_strobe;
	logic                              cmd_strobe;
	logic                              data_strobe;
	logic                              vs_wait;
	logic                              vs_d;
	logic                              vs_rise;
	dec_state_e                        state;
	cmd_e                              opcode;
	logic [$clog2(NUM_TIMING_WORDS):0] word_cnt;
	logic [LED_W-1:0]                  led_overtake;
	logic [LED_W-1:0]                  led_state;

	// New word seen on the host strobe
	assign io_strobe   = i_io_clk & ~rack & ~vs_wait;
	assign cmd_strobe  = io_strobe & i_io_sel & (state == ST_IDLE);
	assign data_strobe = io_strobe & i_io_sel & (state == ST_DATA);
	assign vs_rise     = i_vs_fixed & ~vs_d;

	//////////////////////////////
	// Acknowledge and vsync wait
	//////////////////////////////

	// Ack trails the host clock by two cycles, held while waiting
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			rack     <= 1'b0;
			o_io_ack <= 1'b0;
		end else if (!vs_wait) begin
			rack     <= i_io_clk;
			o_io_ack <= rack;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			vs_wait <= 1'b0;
			vs_d    <= 1'b0;
		end else begin
			vs_d <= i_vs_fixed;
			if (cmd_strobe && i_io_din[7:0] == CMD_VS_WAIT) begin
				vs_wait <= 1'b1;
			end else if (vs_rise) begin
				vs_wait <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Command FSM
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state    <= ST_IDLE;
			opcode   <= CMD_NONE;
			word_cnt <= '0;
		end else if (!i_io_sel) begin
			state <= ST_IDLE;
		end else if (cmd_strobe) begin
			opcode   <= cmd_e'(i_io_din[7:0]);
			word_cnt <= '0;
			state    <= ST_DATA;
		end else if (data_strobe) begin
			// Saturate so long commands cannot alias word 0
			if (~&word_cnt) begin
				word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// Configuration registers
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_width      <= DEF_WIDTH;
			o_hfp        <= DEF_HFP;
			o_hs_len     <= DEF_HS;
			o_hbp        <= DEF_HBP;
			o_height     <= DEF_HEIGHT;
			o_vfp        <= DEF_VFP;
			o_vs_len     <= DEF_VS;
			o_vbp        <= DEF_VBP;
			o_vset       <= '0;
			o_hset       <= '0;
			led_overtake <= '0;
			led_state    <= '0;
		end else if (data_strobe) begin
			case (opcode)
				CMD_TIMING: begin
					if (word_cnt < NUM_TIMING_WORDS) begin
						case (word_cnt[2:0])
							3'd0: o_width  <= i_io_din[TIMING_W-1:0];
							3'd1: o_hfp    <= i_io_din[TIMING_W-1:0];
							3'd2: o_hs_len <= i_io_din[TIMING_W-1:0];
							3'd3: o_hbp    <= i_io_din[TIMING_W-1:0];
							3'd4: o_height <= i_io_din[TIMING_W-1:0];
							3'd5: o_vfp    <= i_io_din[TIMING_W-1:0];
							3'd6: o_vs_len <= i_io_din[TIMING_W-1:0];
							3'd7: o_vbp    <= i_io_din[TIMING_W-1:0];
						endcase
					end
				end
				CMD_LED: begin
					if (word_cnt == '0) begin
						{led_overtake, led_state} <= i_io_din;
					end
				end
				CMD_VSET: begin
					if (word_cnt == '0) begin
						o_vset <= i_io_din[TIMING_W-1:0];
					end
				end
				CMD_HSET: begin
					if (word_cnt == '0) begin
						o_hset <= i_io_din[TIMING_W-1:0];
					end
				end
				// Other opcodes swallow their data
				default: ;
			endcase
		end
	end

	assign o_led = led_overtake & led_state;

	// Host sees no ack movement until the vsync edge
	ack_frozen_in_wait: assert property (
		@(posedge clk_sys) disable iff (resetd)
		vs_wait |=> $stable(o_io_ack)
	);

	timing_cnt_no_wrap: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(data_strobe && opcode == CMD_TIMING) |=> word_cnt != '0
	);

endmodule

/* verilog/sync_polarity_fix.sv */
module sync_polarity_fix
	import video_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] run_cnt;
	logic [SYNC_CNT_W-1:0] high_len;
	logic [SYNC_CNT_W-1:0] low_len;
	logic                  pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1       <= 1'b0;
			s2       <= 1'b0;
			run_cnt  <= '0;
			high_len <= '0;
			low_len  <= '0;
			pol      <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Rising edge closes a low run, falling edge a high run
			if (s1 & ~s2) begin
				low_len <= run_cnt;
			end
			if (~s1 & s2) begin
				high_len <= run_cnt;
			end

			if (s1 != s2) begin
				run_cnt <= '0;
			end else if (~&run_cnt) begin
				run_cnt <= run_cnt + 1'b1;
			end

			// Longer high phase means the pulse is active low
			pol <= high_len > low_len;
		end
	end

	assign o_sync = i_sync ^ pol;

endmodule

/* verilog/csync_gen.sv */
module csync_gen
	import video_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hs,
	input  logic i_vs,
	output logic o_csync
);

	logic                  prev_hs;
	logic                  hs_edge;
	logic                  hs_rise;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic                  csync_hs;
	logic                  csync_vs;

	assign hs_edge = prev_hs ^ i_hs;
	assign hs_rise = i_hs & ~prev_hs;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			csync_hs <= 1'b0;
			csync_vs <= 1'b0;
		end else begin
			prev_hs <= i_hs;

			// Phase counter, restarted on every hsync edge
			if (hs_edge) begin
				h_cnt <= '0;
				if (i_hs) begin
					line_len <= h_cnt - hs_len;
				end else begin
					hs_len <= h_cnt;
				end
			end else begin
				h_cnt <= h_cnt + 1'b1;
			end

			// Serrated pulses during vsync, plain hsync elsewhere
			if (!i_vs) begin
				csync_hs <= i_hs;
			end else if (hs_rise) begin
				csync_hs <= 1'b0;
			end else if (h_cnt == line_len) begin
				csync_hs <= 1'b1;
			end

			csync_vs <= i_vs;
		end
	end

	assign o_csync = csync_vs ^ csync_hs;

	// Once a full hsync pulse was measured, the line length is usable
	line_len_known: assert property (
		@(posedge clk_sys) disable iff (resetd)
		(hs_rise && hs_len != '0) |=> line_len != '0
	);

endmodule

/* verilog/timing_calc.sv */
module timing_calc
	import video_pkg::*;
(
	input  logic    clk_sys,
	input  logic    resetd,
	input  timing_t i_width,
	input  timing_t i_hfp,
	input  timing_t i_hs_len,
	input  timing_t i_hbp,
	input  timing_t i_height,
	input  timing_t i_vfp,
	input  timing_t i_vs_len,
	input  timing_t i_vbp,
	input  timing_t i_vset,
	input  timing_t i_hset,
	output timing_t o_htotal,
	output timing_t o_hsstart,
	output timing_t o_hsend,
	output timing_t o_vtotal,
	output timing_t o_vsstart,
	output timing_t o_vsend,
	output timing_t o_hmin,
	output timing_t o_hmax,
	output timing_t o_vmin,
	output timing_t o_vmax
);

	timing_t htotal_s;
	timing_t hsstart_s;
	timing_t hsend_s;
	timing_t vtotal_s;
	timing_t vsstart_s;
	timing_t vsend_s;
	timing_t width_s;
	timing_t height_s;
	timing_t eff_w;
	timing_t eff_h;
	timing_t hofs;
	timing_t vofs;

	//////////////////////////////
	// Stage 1, sums and effective size
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		hsstart_s <= i_width + i_hfp;
		hsend_s   <= i_width + i_hfp + i_hs_len;
		htotal_s  <= i_width + i_hfp + i_hs_len + i_hbp;
		vsstart_s <= i_height + i_vfp;
		vsend_s   <= i_height + i_vfp + i_vs_len;
		vtotal_s  <= i_height + i_vfp + i_vs_len + i_vbp;
		width_s   <= i_width;
		height_s  <= i_height;
		// A cap only applies when set and smaller than the frame
		eff_w     <= (i_hset != '0 && i_hset < i_width) ? i_hset : i_width;
		eff_h     <= (i_vset != '0 && i_vset < i_height) ? i_vset : i_height;
	end

	// Centring offsets
	assign hofs = (width_s - eff_w) >> 1;
	assign vofs = (height_s - eff_h) >> 1;

	//////////////////////////////
	// Stage 2, outputs and window
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_htotal  <= DEF_WIDTH + DEF_HFP + DEF_HS + DEF_HBP;
			o_hsstart <= DEF_WIDTH + DEF_HFP;
			o_hsend   <= DEF_WIDTH + DEF_HFP + DEF_HS;
			o_vtotal  <= DEF_HEIGHT + DEF_VFP + DEF_VS + DEF_VBP;
			o_vsstart <= DEF_HEIGHT + DEF_VFP;
			o_vsend   <= DEF_HEIGHT + DEF_VFP + DEF_VS;
			o_hmin    <= '0;
			o_hmax    <= DEF_WIDTH - 1'b1;
			o_vmin    <= '0;
			o_vmax    <= DEF_HEIGHT - 1'b1;
		end else begin
			o_htotal  <= htotal_s;
			o_hsstart <= hsstart_s;
			o_hsend   <= hsend_s;
			o_vtotal  <= vtotal_s;
			o_vsstart <= vsstart_s;
			o_vsend   <= vsend_s;
			o_hmin    <= hofs;
			o_hmax    <= hofs + eff_w - 1'b1;
			o_vmin    <= vofs;
			o_vmax    <= vofs + eff_h - 1'b1;
		end
	end

	window_ordered: assert property (
		@(posedge clk_sys) disable iff (resetd)
		o_hmax >= o_hmin
	);

endmodule

/* verilog/video_ctrl_top.sv */
module video_ctrl_top
	import video_pkg::*;
(
	input  logic             clk_sys,
	input  logic             resetd,
	input  logic             i_io_sel,
	input  logic             i_io_clk,
	input  logic [IO_W-1:0]  i_io_din,
	input  logic             i_hs,
	input  logic             i_vs,
	output logic             o_io_ack,
	output logic [LED_W-1:0] o_led,
	output logic             o_hs,
	output logic             o_vs,
	output logic             o_csync,
	output timing_t          o_htotal,
	output timing_t          o_hsstart,
	output timing_t          o_hsend,
	output timing_t          o_vtotal,
	output timing_t          o_vsstart,
	output timing_t          o_vsend,
	output timing_t          o_hmin,
	output timing_t          o_hmax,
	output timing_t          o_vmin,
	output timing_t          o_vmax
);

	// Index 0 horizontal, index 1 vertical
	logic [NUM_SYNC-1:0] sync_raw;
	logic [NUM_SYNC-1:0] sync_fixed;

	timing_t width;
	timing_t hfp;
	timing_t hs_len;
	timing_t hbp;
	timing_t height;
	timing_t vfp;
	timing_t vs_len;
	timing_t vbp;
	timing_t vset;
	timing_t hset;

	assign sync_raw = {i_vs, i_hs};
	assign o_hs     = sync_fixed[0];
	assign o_vs     = sync_fixed[1];

	//////////////////////////////
	// Host commands
	//////////////////////////////

	hps_cmd_decoder u_decoder (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_io_sel   (i_io_sel),
		.i_io_clk   (i_io_clk),
		.i_io_din   (i_io_din),
		.i_vs_fixed (sync_fixed[1]),
		.o_io_ack   (o_io_ack),
		.o_led      (o_led),
		.o_width    (width),
		.o_hfp      (hfp),
		.o_hs_len   (hs_len),
		.o_hbp      (hbp),
		.o_height   (height),
		.o_vfp      (vfp),
		.o_vs_len   (vs_len),
		.o_vbp      (vbp),
		.o_vset     (vset),
		.o_hset     (hset)
	);

	timing_calc u_timing (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_width   (width),
		.i_hfp     (hfp),
		.i_hs_len  (hs_len),
		.i_hbp     (hbp),
		.i_height  (height),
		.i_vfp     (vfp),
		.i_vs_len  (vs_len),
		.i_vbp     (vbp),
		.i_vset    (vset),
		.i_hset    (hset),
		.o_htotal  (o_htotal),
		.o_hsstart (o_hsstart),
		.o_hsend   (o_hsend),
		.o_vtotal  (o_vtotal),
		.o_vsstart (o_vsstart),
		.o_vsend   (o_vsend),
		.o_hmin    (o_hmin),
		.o_hmax    (o_hmax),
		.o_vmin    (o_vmin),
		.o_vmax    (o_vmax)
	);

	//////////////////////////////
	// Sync path
	//////////////////////////////

	for (genvar i = 0; i < NUM_SYNC; i++) begin : g_sync_fix
		sync_polarity_fix u_fix (
			.clk_sys (clk_sys),
			.resetd  (resetd),
			.i_sync  (sync_raw[i]),
			.o_sync  (sync_fixed[i])
		);
	end

	csync_gen u_csync (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_hs    (sync_fixed[0]),
		.i_vs    (sync_fixed[1]),
		.o_csync (o_csync)
	);

endmodule

/* dv/tb_clock_gen.sv */
module tb_clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic resetd
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Reset released on a rising edge, like any synchronous input
	initial begin
		resetd = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		resetd <= 1'b0;
	end

endmodule

/* dv/video_checker.sv */
module video_checker
	import video_pkg::*;
#(
	parameter int SETTLE_CYCLES = 2400,
	parameter int ACK_SLACK     = 4
) (
	input  logic                    clk_sys,
	input  logic                    resetd,
	input  logic                    i_io_clk,
	input  logic                    i_hs,
	input  logic                    i_vs,
	input  logic                    o_io_ack,
	input  logic [LED_W-1:0]        o_led,
	input  logic                    o_hs,
	input  logic                    o_vs,
	input  logic                    o_csync,
	input  timing_t                 o_htotal,
	input  timing_t                 o_hsstart,
	input  timing_t                 o_hsend,
	input  timing_t                 o_vtotal,
	input  timing_t                 o_vsstart,
	input  timing_t                 o_vsend,
	input  timing_t                 o_hmin,
	input  timing_t                 o_hmax,
	input  timing_t                 o_vmin,
	input  timing_t                 o_vmax,
	input  logic [10*TIMING_W-1:0]  i_exp,
	input  logic [LED_W-1:0]        i_exp_led,
	input  logic                    i_check,
	input  logic                    i_wait_armed,
	output int                      o_errors,
	output int                      o_checks
);

	int   cycles;
	int   since_vs;
	logic vs_seen;
	logic prev_hs;
	logic prev_vs;

	// Expected field j, htotal first
	function automatic int field(input int j);
		return i_exp[(9 - j) * TIMING_W +: TIMING_W];
	endfunction

	task automatic check_val(input string name, input int got, input int want);
		o_checks++;
		if (got != want) begin
			o_errors++;
			$display("Mismatch at time %0t: %s is %0d, expected %0d", $time, name, got, want);
		end
	endtask

	//////////////////////////////
	// Sampled on the falling edge
	//////////////////////////////

	always @(negedge clk_sys) begin
		if (resetd) begin
			cycles   = 0;
			since_vs = 0;
			vs_seen  = 1'b0;
			o_errors = 0;
			o_checks = 0;
		end else begin
			cycles++;
			// Both polarities known after a few frames
			if (cycles > SETTLE_CYCLES) begin
				check_val("o_hs", o_hs, !i_hs);
				check_val("o_vs", o_vs, !i_vs);
				if (!prev_vs) begin
					check_val("o_csync", o_csync, prev_hs);
				end
			end

			if (i_check) begin
				check_val("o_htotal", o_htotal, field(0));
				check_val("o_hsstart", o_hsstart, field(1));
				check_val("o_hsend", o_hsend, field(2));
				check_val("o_vtotal", o_vtotal, field(3));
				check_val("o_vsstart", o_vsstart, field(4));
				check_val("o_vsend", o_vsend, field(5));
				check_val("o_hmin", o_hmin, field(6));
				check_val("o_hmax", o_hmax, field(7));
				check_val("o_vmin", o_vmin, field(8));
				check_val("o_vmax", o_vmax, field(9));
				check_val("o_led", o_led, i_exp_led);
				check_val("o_io_ack", o_io_ack, 0);
			end

			// Held handshake, released by the fixed vsync edge
			if (!i_wait_armed) begin
				vs_seen  = 1'b0;
				since_vs = 0;
			end else begin
				if (o_vs && !prev_vs) begin
					vs_seen = 1'b1;
				end
				if (vs_seen) begin
					since_vs++;
				end
				if (i_io_clk && o_io_ack) begin
					o_checks++;
					if (!vs_seen) begin
						o_errors++;
						$display("Host handshake completed at time %0t before the vsync edge",
							$time);
					end
				end else if (since_vs == ACK_SLACK + 1) begin
					o_errors++;
					$display("Acknowledge still held %0d cycles after the vsync edge at time %0t",
						ACK_SLACK + 1, $time);
				end
			end
		end
		prev_hs = o_hs;
		prev_vs = o_vs;
	end

endmodule

/* dv/tb_video_ctrl.sv */
module tb_video_ctrl
	import video_pkg::*;
;

	localparam int LINE_CYCLES  = 40;
	localparam int HS_CYCLES    = 4;
	localparam int FRAME_LINES  = 20;
	localparam int VS_LINES     = 2;
	localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
	localparam int NUM_ROWS     = 10;
	localparam int MAX_CYCLES   = NUM_ROWS * (NUM_TIMING_WORDS + 1) * 40 + 10 * FRAME_CYCLES;
	localparam int HCAP         = 901;

	// Sums of the 1280x720 timing
	localparam logic [6*TIMING_W-1:0] SUMS_720 = {12'd1650, 12'd1390, 12'd1430,
		12'd750, 12'd725, 12'd730};

	logic                   clk_sys;
	logic                   resetd;
	logic                   i_io_sel;
	logic                   i_io_clk;
	logic [IO_W-1:0]        i_io_din;
	logic                   i_hs;
	logic                   i_vs;
	logic                   o_io_ack;
	logic [LED_W-1:0]       o_led;
	logic                   o_hs;
	logic                   o_vs;
	logic                   o_csync;
	timing_t                o_htotal;
	timing_t                o_hsstart;
	timing_t                o_hsend;
	timing_t                o_vtotal;
	timing_t                o_vsstart;
	timing_t                o_vsend;
	timing_t                o_hmin;
	timing_t                o_hmax;
	timing_t                o_vmin;
	timing_t                o_vmax;
	logic [10*TIMING_W-1:0] i_exp;
	logic [LED_W-1:0]       i_exp_led;
	logic                   i_check;
	logic                   i_wait_armed;
	int                     o_errors;
	int                     o_checks;

	// Stimulus table with data word 0 and htotal in the top bits
	logic [7:0]             row_op   [NUM_ROWS];
	int                     row_len  [NUM_ROWS];
	logic [8*IO_W-1:0]      row_data [NUM_ROWS];
	logic [10*TIMING_W-1:0] row_exp  [NUM_ROWS];
	logic [LED_W-1:0]       row_led  [NUM_ROWS];
	int                     num_rows = 0;
	logic [31:0]            lfsr_state = 32'h6e44_c8c6;

	tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) u_clk (.*);

	video_ctrl_top dut (.*);

	video_checker #(.SETTLE_CYCLES(3 * FRAME_CYCLES)) u_checker (.*);

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic timing_t next_bits(input int nbits);
		timing_t w;
		logic    fb;
		w = '0;
		for (int i = 0; i < nbits; i++) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			w          = {w[TIMING_W-2:0], fb};
		end
		return w;
	endfunction

	task automatic add_row(input logic [7:0] op, input int n, input logic [8*IO_W-1:0] d,
		input logic [10*TIMING_W-1:0] exp_vec, input logic [LED_W-1:0] led);
		row_op[num_rows]   = op;
		row_len[num_rows]  = n;
		row_data[num_rows] = d;
		row_exp[num_rows]  = exp_vec;
		row_led[num_rows]  = led;
		num_rows++;
	endtask

	// Random timing with the window still capped by HCAP
	task automatic add_lfsr_row();
		timing_t           v [8];
		timing_t           eff;
		timing_t           hmin;
		logic [8*IO_W-1:0] d;
		for (int k = 0; k < 8; k++) begin
			// 10 bits keep every sum inside 12
			v[k]                  = next_bits(10);
			d[(7-k)*IO_W +: IO_W] = IO_W'(v[k]);
		end
		eff  = (HCAP != 0 && HCAP < v[0]) ? timing_t'(HCAP) : v[0];
		hmin = (v[0] - eff) >> 1;
		add_row(CMD_TIMING, 8, d, {v[0] + v[1] + v[2] + v[3], v[0] + v[1], v[0] + v[1] + v[2],
			v[4] + v[5] + v[6] + v[7], v[4] + v[5], v[4] + v[5] + v[6],
			hmin, hmin + eff - 12'd1, 12'd0, v[4] - 12'd1}, 8'h30);
	endtask

	task automatic wait_ack(input logic lvl);
		do begin
			@(negedge clk_sys);
		end while (o_io_ack !== lvl);
	endtask

	// One word raises the strobe, waits for ack and lowers it again
	task automatic host_word(input logic [IO_W-1:0] w, input logic arm);
		@(posedge clk_sys);
		i_io_din     <= w;
		i_io_clk     <= 1'b1;
		i_wait_armed <= arm;
		wait_ack(1'b1);
		@(posedge clk_sys);
		i_io_clk     <= 1'b0;
		i_wait_armed <= 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic send_command(input logic [7:0] op, input int n,
		input logic [8*IO_W-1:0] d, input logic arm);
		@(posedge clk_sys);
		i_io_sel <= 1'b1;
		host_word({8'h00, op}, arm);
		for (int k = 0; k < n; k++) begin
			host_word(d[(7-k)*IO_W +: IO_W], 1'b0);
		end
		@(posedge clk_sys);
		i_io_sel <= 1'b0;
	endtask

	task automatic request_check(input int r);
		repeat (2) @(posedge clk_sys);
		i_exp     <= row_exp[r];
		i_exp_led <= row_led[r];
		i_check   <= 1'b1;
		@(posedge clk_sys);
		i_check   <= 1'b0;
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		i_io_sel     = 1'b0;
		i_io_clk     = 1'b0;
		i_io_din     = '0;
		i_hs         = 1'b1;
		i_vs         = 1'b1;
		i_exp        = '0;
		i_exp_led    = '0;
		i_check      = 1'b0;
		i_wait_armed = 1'b0;

		add_row(CMD_NONE, 0, '0, {12'd2204, 12'd2008, 12'd2056, 12'd1125, 12'd1084,
			12'd1089, 12'd0, 12'd1919, 12'd0, 12'd1079}, 8'h00);
		add_row(CMD_TIMING, 8, {16'd1280, 16'd110, 16'd40, 16'd220, 16'd720, 16'd5, 16'd5,
			16'd20}, {SUMS_720, 12'd0, 12'd1279, 12'd0, 12'd719}, 8'h00);
		add_row(CMD_HSET, 1, {16'd1000, 112'd0}, {SUMS_720, 12'd140, 12'd1139, 12'd0, 12'd719},
			8'h00);
		add_row(CMD_VSET, 1, {16'd600, 112'd0}, {SUMS_720, 12'd140, 12'd1139, 12'd60, 12'd659},
			8'h00);
		add_row(CMD_HSET, 1, {16'd1280, 112'd0}, {SUMS_720, 12'd0, 12'd1279, 12'd60, 12'd659},
			8'h00);
		add_row(CMD_VSET, 1, '0, {SUMS_720, 12'd0, 12'd1279, 12'd0, 12'd719}, 8'h00);
		add_row(CMD_LED, 1, {16'hf03c, 112'd0}, {SUMS_720, 12'd0, 12'd1279, 12'd0, 12'd719},
			8'h30);
		// Unknown opcode whose words change nothing
		add_row(8'h55, 3, {16'd7, 16'd3, 16'd1, 80'd0},
			{SUMS_720, 12'd0, 12'd1279, 12'd0, 12'd719}, 8'h30);
		add_row(CMD_HSET, 1, {16'(HCAP), 112'd0}, {SUMS_720, 12'd189, 12'd1089, 12'd0, 12'd719},
			8'h30);
		add_lfsr_row();

		wait (!resetd);
		repeat (2) @(posedge clk_sys);
		for (int r = 0; r < num_rows; r++) begin
			if (row_op[r] != CMD_NONE) begin
				send_command(row_op[r], row_len[r], row_data[r], 1'b0);
			end
			request_check(r);
		end

		// Vsync wait sent just after a raw vsync pulse ends
		repeat (3 * FRAME_CYCLES) @(posedge clk_sys);
		@(posedge i_vs);
		send_command(CMD_VS_WAIT, 0, '0, 1'b1);
		repeat (FRAME_CYCLES) @(posedge clk_sys);

		$display("Checks: %0d, errors: %0d", o_checks, o_errors);
		if (o_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Scaled raster with active low syncs
	initial begin
		wait (!resetd);
		forever begin
			for (int line = 0; line < FRAME_LINES; line++) begin
				for (int c = 0; c < LINE_CYCLES; c++) begin
					@(posedge clk_sys);
					i_hs <= (c >= HS_CYCLES);
					i_vs <= (line >= VS_LINES);
				end
			end
		end
	end

	initial begin
		repeat (MAX_CYCLES) @(posedge clk_sys);
		$display("Timeout after %0d cycles, the test sequence did not reach its end",
			MAX_CYCLES);
		$display("Checks: %0d, errors: %0d", o_checks, o_errors);
		$display("Simulation failed");
		$finish;
	end

endmodule

/* tb.f */
verilog/video_pkg.sv
verilog/hps_cmd_decoder.sv
verilog/sync_polarity_fix.sv
verilog/csync_gen.sv
verilog/timing_calc.sv
verilog/video_ctrl_top.sv
dv/tb_clock_gen.sv
dv/video_checker.sv
dv/tb_video_ctrl.sv
